// File: bench/tb_bpu.sv
/* Branch predictor testbench
   Applies a stimulus table and compares each prediction with a reference model */
module tb_bpu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BASE_IDX_W   = 6;
    localparam int TAG_IDX_W    = 5;
    localparam int RESET_CYCLES = 10;
    localparam int SWEEP_LEN    = 1 << ((BASE_IDX_W > TAG_IDX_W) ? BASE_IDX_W : TAG_IDX_W);
    localparam int N_DIRECTED   = 30;
    localparam int N_RANDOM     = 40;
    localparam int CYCLE_LIMIT  = SWEEP_LEN + 4 * (N_DIRECTED + N_RANDOM) + 100;

    typedef struct packed {
        bpu_pkg::pc_t pc;
        logic         taken;
    } stim_row_t;

    logic                clk = 1'b0;
    logic                rst_n_i;
    logic                query_valid_i;
    bpu_pkg::pc_t        query_pc_i;
    logic                pred_valid_o;
    bpu_pkg::pred_t      pred_o;
    logic                resolve_valid_i;
    bpu_pkg::pc_t        resolve_pc_i;
    logic                resolve_taken_i;
    bpu_pkg::pred_meta_t resolve_meta_i;
    logic                ready_o;

    // Reference copy of both tables and the history
    bpu_pkg::base_ctr_t  base_m   [0:(1<<BASE_IDX_W)-1];
    logic                tvalid_m [0:(1<<TAG_IDX_W)-1];
    bpu_pkg::tag_t       ttag_m   [0:(1<<TAG_IDX_W)-1];
    bpu_pkg::tag_ctr_t   tctr_m   [0:(1<<TAG_IDX_W)-1];
    bpu_pkg::hist_t      hist_m;
    stim_row_t           rows [$];
    logic [31:0]         lcg_state = 32'd34;
    int                  cycle_cnt = 0;

    always #50 clk = ~clk;

    bpu_top #(
        .BASE_IDX_W(BASE_IDX_W),
        .TAG_IDX_W (TAG_IDX_W)
    ) u_bpu_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .query_valid_i  (query_valid_i),
        .query_pc_i     (query_pc_i),
        .pred_valid_o   (pred_valid_o),
        .pred_o         (pred_o),
        .resolve_valid_i(resolve_valid_i),
        .resolve_pc_i   (resolve_pc_i),
        .resolve_taken_i(resolve_taken_i),
        .resolve_meta_i (resolve_meta_i),
        .ready_o        (ready_o)
    );

    task automatic report_failure();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            report_failure();
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns %s: got %b, expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_base_ctr(input string name, input bpu_pkg::base_ctr_t got,
                                  input bpu_pkg::base_ctr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_tag_ctr(input string name, input bpu_pkg::tag_ctr_t got,
                                 input bpu_pkg::tag_ctr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_hist(input string name, input bpu_pkg::hist_t got,
                              input bpu_pkg::hist_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Small PC set, most of them sharing a base index
    function automatic bpu_pkg::pc_t alias_pc(input logic [2:0] sel);
        case (sel)
            3'd0: return 32'h0000_1040;
            3'd1: return 32'h0000_2040;
            3'd2: return 32'h0000_1140;
            3'd3: return 32'h0000_2080;
            3'd4: return 32'h0000_1044;
            3'd5: return 32'h0000_3040;
            3'd6: return 32'h0000_20C0;
            default: return 32'h0000_1000;
        endcase
    endfunction

    function automatic logic [TAG_IDX_W-1:0] tag_index(input bpu_pkg::pc_t pc,
                                                       input bpu_pkg::hist_t hist);
        logic [2*bpu_pkg::HIST_W-1:0] hist_rep;
        hist_rep = {hist, hist};
        return pc[TAG_IDX_W+1:2] ^ hist_rep[TAG_IDX_W-1:0];
    endfunction

    function automatic bpu_pkg::tag_t tag_of(input bpu_pkg::pc_t pc, input bpu_pkg::hist_t hist);
        return pc[TAG_IDX_W+2 +: bpu_pkg::TAG_W] ^ hist;
    endfunction

    function automatic bpu_pkg::pred_t model_predict(input bpu_pkg::pc_t pc);
        bpu_pkg::pred_t       p;
        logic [TAG_IDX_W-1:0] ti;
        ti              = tag_index(pc, hist_m);
        p.meta.hit      = tvalid_m[ti] && (ttag_m[ti] == tag_of(pc, hist_m));
        p.meta.base_ctr = base_m[pc[BASE_IDX_W+1:2]];
        p.meta.tag_ctr  = tctr_m[ti];
        p.meta.hist     = hist_m;
        p.taken = p.meta.hit ? p.meta.tag_ctr[2] : p.meta.base_ctr[1];
        return p;
    endfunction

    task automatic model_resolve(input stim_row_t row, input bpu_pkg::pred_meta_t meta);
        logic [TAG_IDX_W-1:0] ti;
        logic                 pred_dir;
        ti       = tag_index(row.pc, meta.hist);
        pred_dir = meta.hit ? meta.tag_ctr[2] : meta.base_ctr[1];
        if (row.taken && meta.base_ctr != 2'd3) begin
            base_m[row.pc[BASE_IDX_W+1:2]] = meta.base_ctr + 2'd1;
        end else if (!row.taken && meta.base_ctr != 2'd0) begin
            base_m[row.pc[BASE_IDX_W+1:2]] = meta.base_ctr - 2'd1;
        end
        if (meta.hit) begin
            if (row.taken && meta.tag_ctr != 3'd7) begin
                tctr_m[ti] = meta.tag_ctr + 3'd1;
            end else if (!row.taken && meta.tag_ctr != 3'd0) begin
                tctr_m[ti] = meta.tag_ctr - 3'd1;
            end
        end else if (pred_dir != row.taken) begin
            tvalid_m[ti] = 1'b1;
            ttag_m[ti]   = tag_of(row.pc, meta.hist);
            tctr_m[ti]   = row.taken ? bpu_pkg::TAG_CTR_WEAK_T : bpu_pkg::TAG_CTR_WEAK_NT;
        end
        hist_m = {hist_m[bpu_pkg::HIST_W-2:0], row.taken};
    endtask

    task automatic add_rows(input bpu_pkg::pc_t pc, input logic taken, input int count);
        repeat (count) rows.push_back('{pc: pc, taken: taken});
    endtask

    task automatic build_table();
        // Saturate up, allocate then train to 7, override and train to 0, other history
        add_rows(32'h0000_1040, 1'b1, 9);
        add_rows(32'h0000_2080, 1'b1, 6);
        add_rows(32'h0000_1040, 1'b0, 14);
        add_rows(32'h0000_2080, 1'b1, 1);
        for (int i = 0; i < N_RANDOM; i++) begin
            lcg_state = lcg_next(lcg_state);
            rows.push_back('{pc: alias_pc(lcg_state[18:16]), taken: lcg_state[25:24] != 2'b00});
        end
    endtask

    initial begin
        bpu_pkg::pred_t exp_pred;
        bpu_pkg::pred_t got_pred;
        rst_n_i         = 1'b0;
        query_valid_i   = 1'b0;
        query_pc_i      = '0;
        resolve_valid_i = 1'b0;
        resolve_pc_i    = '0;
        resolve_taken_i = 1'b0;
        resolve_meta_i  = '0;
        hist_m          = '0;
        for (int i = 0; i < (1 << BASE_IDX_W); i++) base_m[i] = bpu_pkg::BASE_CTR_INIT;
        for (int i = 0; i < (1 << TAG_IDX_W); i++) begin
            tvalid_m[i] = 1'b0;
            ttag_m[i]   = '0;
            tctr_m[i]   = '0;
        end
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;

        // Strobes up to the last sweep cycle must be ignored
        for (int i = 0; i < SWEEP_LEN - 1; i++) begin
            @(posedge clk);
            query_valid_i   <= 1'b1;
            query_pc_i      <= 32'h0000_1040;
            resolve_valid_i <= 1'b1;
            resolve_pc_i    <= 32'h0000_1040;
            resolve_taken_i <= 1'b1;
            @(negedge clk);
            check_bit("ready_o", ready_o, 1'b0);
            check_bit("pred_valid_o", pred_valid_o, 1'b0);
        end
        @(posedge clk);
        query_valid_i   <= 1'b0;
        resolve_valid_i <= 1'b0;
        do begin
            @(negedge clk);
            check_bit("pred_valid_o", pred_valid_o, 1'b0);
        end while (ready_o !== 1'b1);

        foreach (rows[r]) begin
            @(posedge clk);
            query_valid_i <= 1'b1;
            query_pc_i    <= rows[r].pc;
            exp_pred = model_predict(rows[r].pc);
            @(posedge clk);
            query_valid_i <= 1'b0;
            @(negedge clk);
            got_pred = pred_o;
            check_bit("pred_valid_o", pred_valid_o, 1'b1);
            check_bit("pred_o.taken", got_pred.taken, exp_pred.taken);
            check_bit("pred_o.meta.hit", got_pred.meta.hit, exp_pred.meta.hit);
            check_base_ctr("pred_o.meta.base_ctr", got_pred.meta.base_ctr, exp_pred.meta.base_ctr);
            check_tag_ctr("pred_o.meta.tag_ctr", got_pred.meta.tag_ctr, exp_pred.meta.tag_ctr);
            check_hist("pred_o.meta.hist", got_pred.meta.hist, exp_pred.meta.hist);
            @(posedge clk);
            resolve_valid_i <= 1'b1;
            resolve_pc_i    <= rows[r].pc;
            resolve_taken_i <= rows[r].taken;
            resolve_meta_i  <= got_pred.meta;
            model_resolve(rows[r], exp_pred.meta);
            @(posedge clk);
            resolve_valid_i <= 1'b0;
        end
        @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

// File: flist.f
logic/bpu_pkg.sv
logic/bpu_bram.sv
logic/base_predictor.sv
logic/tagged_predictor.sv
logic/bpu_ctrl.sv
logic/bpu_top.sv
bench/tb_bpu.sv

// File: logic/base_predictor.sv
/* Bimodal base predictor
   PC-indexed table of 2-bit saturating counters, cleared by the reset sweep */
module base_predictor #(
    parameter int BASE_IDX_W = 10
) (
    input  logic                  clk,
    // Query
    input  bpu_pkg::pc_t          query_pc_i,
    output bpu_pkg::base_ctr_t    ctr_o,
    // Update
    input  logic                  upd_en_i,
    input  bpu_pkg::pc_t          upd_pc_i,
    input  logic                  upd_taken_i,
    input  bpu_pkg::base_ctr_t    upd_ctr_i,
    // Clear sweep
    input  logic                  clear_i,
    input  logic [BASE_IDX_W-1:0] clear_idx_i
);

    logic [BASE_IDX_W-1:0] query_idx;
    logic [BASE_IDX_W-1:0] upd_idx;
    bpu_pkg::base_ctr_t    ctr_step;
    logic                  wr_en;
    logic [BASE_IDX_W-1:0] wr_idx;
    bpu_pkg::base_ctr_t    wr_ctr;

    // Word index, byte offset dropped
    assign query_idx = query_pc_i[BASE_IDX_W+1:2];
    assign upd_idx   = upd_pc_i[BASE_IDX_W+1:2];

    // Step the counter seen at query time, holding at either end
    always_comb begin
        if (upd_taken_i) begin
            ctr_step = (upd_ctr_i == '1) ? upd_ctr_i : upd_ctr_i + 1'b1;
        end else begin
            ctr_step = (upd_ctr_i == '0) ? upd_ctr_i : upd_ctr_i - 1'b1;
        end
    end

    // Sweep owns the write port until it ends
    always_comb begin
        if (clear_i) begin
            wr_en  = 1'b1;
            wr_idx = clear_idx_i;
            wr_ctr = bpu_pkg::BASE_CTR_INIT;
        end else begin
            wr_en  = upd_en_i;
            wr_idx = upd_idx;
            wr_ctr = ctr_step;
        end
    end

    bpu_bram #(
        .DATA_W(bpu_pkg::BASE_CTR_W),
        .ADDR_W(BASE_IDX_W)
    ) u_table (
        .clk      (clk),
        .rd_addr_i(query_idx),
        .rd_data_o(ctr_o),
        .wr_en_i  (wr_en),
        .wr_addr_i(wr_idx),
        .wr_data_i(wr_ctr)
    );

endmodule

// File: logic/bpu_bram.sv
/* Simple dual-port block RAM
   Port A reads with one cycle of latency, port B writes */
module bpu_bram #(
    parameter int DATA_W = 8,
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output logic [DATA_W-1:0] rd_data_o,
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  logic [DATA_W-1:0] wr_data_i
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [0:DEPTH-1];

    // Read-first, so a same-address write shows up one cycle later
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

// File: logic/bpu_ctrl.sv
/* Predictor control
   Clear sweep, global history, provider choice and table update decisions */
module bpu_ctrl #(
    parameter  int BASE_IDX_W = 10,
    parameter  int TAG_IDX_W  = 8,
    localparam int CLR_W      = (BASE_IDX_W > TAG_IDX_W) ? BASE_IDX_W : TAG_IDX_W
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                query_valid_i,
    input  logic                resolve_valid_i,
    input  logic                resolve_taken_i,
    input  bpu_pkg::pred_meta_t resolve_meta_i,
    // Table read data, one cycle after the query
    input  bpu_pkg::base_ctr_t  base_ctr_i,
    input  logic                tag_hit_i,
    input  bpu_pkg::tag_ctr_t   tag_ctr_i,
    // Table control
    output bpu_pkg::hist_t      hist_o,
    output logic                base_upd_en_o,
    output bpu_pkg::tag_op_e    tag_op_o,
    output logic                clear_o,
    output logic [CLR_W-1:0]    clear_idx_o,
    // Status and prediction
    output logic                ready_o,
    output logic                pred_valid_o,
    output bpu_pkg::pred_t      pred_o
);

    bpu_pkg::ctrl_state_e state_q;
    bpu_pkg::ctrl_state_e state_d;
    logic [CLR_W-1:0]     clear_idx_q;
    bpu_pkg::hist_t       hist_q;
    bpu_pkg::hist_t       query_hist_q;
    logic                 query_valid_q;
    logic                 run;
    logic                 resolve_en;
    logic                 resolve_pred;

    assign run        = (state_q == bpu_pkg::ST_RUN);
    assign resolve_en = resolve_valid_i && run;

    // Sweep ends after the last index is written
    always_comb begin
        state_d = state_q;
        case (state_q)
            bpu_pkg::ST_CLEAR: begin
                if (clear_idx_q == '1) begin
                    state_d = bpu_pkg::ST_RUN;
                end
            end
            bpu_pkg::ST_RUN: begin
                state_d = bpu_pkg::ST_RUN;
            end
            default: begin
                state_d = bpu_pkg::ST_CLEAR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q       <= bpu_pkg::ST_CLEAR;
            clear_idx_q   <= '0;
            hist_q        <= '0;
            query_valid_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            query_valid_q <= query_valid_i && run;
            if (!run) begin
                clear_idx_q <= clear_idx_q + 1'b1;
            end
            // History moves only on resolved outcomes
            if (resolve_en) begin
                hist_q <= {hist_q[bpu_pkg::HIST_W-2:0], resolve_taken_i};
            end
        end
    end

    // Snapshot of the history the tables were indexed with
    always_ff @(posedge clk) begin
        query_hist_q <= hist_q;
    end

    assign hist_o      = hist_q;
    assign clear_o     = !run;
    assign clear_idx_o = clear_idx_q;
    assign ready_o     = run;

    // Tagged entry provides on a hit, base table otherwise
    always_comb begin
        pred_o.taken         = tag_hit_i ? tag_ctr_i[bpu_pkg::TAG_CTR_W-1]
                                         : base_ctr_i[bpu_pkg::BASE_CTR_W-1];
        pred_o.meta.hit      = tag_hit_i;
        pred_o.meta.base_ctr = base_ctr_i;
        pred_o.meta.tag_ctr  = tag_ctr_i;
        pred_o.meta.hist     = query_hist_q;
    end

    assign pred_valid_o = query_valid_q;

    // Direction that was predicted, rebuilt from the returned metadata
    assign resolve_pred = resolve_meta_i.hit ? resolve_meta_i.tag_ctr[bpu_pkg::TAG_CTR_W-1]
                                             : resolve_meta_i.base_ctr[bpu_pkg::BASE_CTR_W-1];

    assign base_upd_en_o = resolve_en;

    always_comb begin
        tag_op_o = bpu_pkg::TAG_NONE;
        if (resolve_en) begin
            if (resolve_meta_i.hit) begin
                tag_op_o = bpu_pkg::TAG_TRAIN;
            end else if (resolve_pred != resolve_taken_i) begin
                // Mispredicted by the base table alone
                tag_op_o = bpu_pkg::TAG_ALLOC;
            end
        end
    end

endmodule

// File: logic/bpu_pkg.sv
/* Branch predictor shared types
   Widths, counter encodings, prediction metadata and tagged table commands */
package bpu_pkg;

    localparam int PC_W       = 32;
    localparam int HIST_W     = 8;
    localparam int TAG_W      = 8;
    localparam int BASE_CTR_W = 2;
    localparam int TAG_CTR_W  = 3;

    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [BASE_CTR_W-1:0] base_ctr_t;
    typedef logic [TAG_CTR_W-1:0]  tag_ctr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    // Newest resolved outcome sits in bit 0
    typedef logic [HIST_W-1:0]     hist_t;

    // Weakly not taken
    localparam base_ctr_t BASE_CTR_INIT = 2'd1;

    // Allocation values, one step on either side of the midpoint
    localparam tag_ctr_t TAG_CTR_WEAK_T  = 3'd4;
    localparam tag_ctr_t TAG_CTR_WEAK_NT = 3'd3;

    // Returned with every prediction, handed back at resolve
    typedef struct packed {
        logic      hit;
        base_ctr_t base_ctr;
        tag_ctr_t  tag_ctr;
        hist_t     hist;
    } pred_meta_t;

    typedef struct packed {
        logic       taken;
        pred_meta_t meta;
    } pred_t;

    // Tagged table write command
    typedef enum logic [1:0] {
        TAG_NONE  = 2'd0,
        TAG_TRAIN = 2'd1,
        TAG_ALLOC = 2'd2
    } tag_op_e;

    // Clear sweep after reset, then normal operation
    typedef enum logic {
        ST_CLEAR = 1'b0,
        ST_RUN   = 1'b1
    } ctrl_state_e;

endpackage

// File: logic/bpu_top.sv
/* Branch direction predictor top
   Bimodal base table plus one history-tagged component */
module bpu_top #(
    parameter int BASE_IDX_W = 10,
    parameter int TAG_IDX_W  = 8
) (
    input  logic                clk,
    input  logic                rst_n_i,
    // Query
    input  logic                query_valid_i,
    input  bpu_pkg::pc_t        query_pc_i,
    output logic                pred_valid_o,
    output bpu_pkg::pred_t      pred_o,
    // Resolve
    input  logic                resolve_valid_i,
    input  bpu_pkg::pc_t        resolve_pc_i,
    input  logic                resolve_taken_i,
    input  bpu_pkg::pred_meta_t resolve_meta_i,
    output logic                ready_o
);

    localparam int CLR_W = (BASE_IDX_W > TAG_IDX_W) ? BASE_IDX_W : TAG_IDX_W;

    bpu_pkg::base_ctr_t base_ctr;
    logic               tag_hit;
    bpu_pkg::tag_ctr_t  tag_ctr;
    bpu_pkg::hist_t     hist;
    logic               base_upd_en;
    bpu_pkg::tag_op_e   tag_op;
    logic               clear;
    logic [CLR_W-1:0]   clear_idx;

    bpu_ctrl #(
        .BASE_IDX_W(BASE_IDX_W),
        .TAG_IDX_W (TAG_IDX_W)
    ) u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .query_valid_i  (query_valid_i),
        .resolve_valid_i(resolve_valid_i),
        .resolve_taken_i(resolve_taken_i),
        .resolve_meta_i (resolve_meta_i),
        .base_ctr_i     (base_ctr),
        .tag_hit_i      (tag_hit),
        .tag_ctr_i      (tag_ctr),
        .hist_o         (hist),
        .base_upd_en_o  (base_upd_en),
        .tag_op_o       (tag_op),
        .clear_o        (clear),
        .clear_idx_o    (clear_idx),
        .ready_o        (ready_o),
        .pred_valid_o   (pred_valid_o),
        .pred_o         (pred_o)
    );

    base_predictor #(
        .BASE_IDX_W(BASE_IDX_W)
    ) u_base (
        .clk        (clk),
        .query_pc_i (query_pc_i),
        .ctr_o      (base_ctr),
        .upd_en_i   (base_upd_en),
        .upd_pc_i   (resolve_pc_i),
        .upd_taken_i(resolve_taken_i),
        .upd_ctr_i  (resolve_meta_i.base_ctr),
        .clear_i    (clear),
        .clear_idx_i(clear_idx[BASE_IDX_W-1:0])
    );

    tagged_predictor #(
        .TAG_IDX_W(TAG_IDX_W)
    ) u_tagged (
        .clk         (clk),
        .query_pc_i  (query_pc_i),
        .query_hist_i(hist),
        .hit_o       (tag_hit),
        .ctr_o       (tag_ctr),
        .upd_op_i    (tag_op),
        .upd_pc_i    (resolve_pc_i),
        .upd_hist_i  (resolve_meta_i.hist),
        .upd_taken_i (resolve_taken_i),
        .upd_ctr_i   (resolve_meta_i.tag_ctr),
        .clear_i     (clear),
        .clear_idx_i (clear_idx[TAG_IDX_W-1:0])
    );

endmodule

// File: logic/tagged_predictor.sv
/* Tagged predictor component
   History-hashed table of tagged 3-bit counters with training and allocation */
module tagged_predictor #(
    parameter int TAG_IDX_W = 8
) (
    input  logic                 clk,
    // Query
    input  bpu_pkg::pc_t         query_pc_i,
    input  bpu_pkg::hist_t       query_hist_i,
    output logic                 hit_o,
    output bpu_pkg::tag_ctr_t    ctr_o,
    // Update
    input  bpu_pkg::tag_op_e     upd_op_i,
    input  bpu_pkg::pc_t         upd_pc_i,
    input  bpu_pkg::hist_t       upd_hist_i,
    input  logic                 upd_taken_i,
    input  bpu_pkg::tag_ctr_t    upd_ctr_i,
    // Clear sweep
    input  logic                 clear_i,
    input  logic [TAG_IDX_W-1:0] clear_idx_i
);

    // History copies needed to cover the index field
    localparam int HREP = (TAG_IDX_W + bpu_pkg::HIST_W - 1) / bpu_pkg::HIST_W;

    typedef struct packed {
        logic              valid;
        bpu_pkg::tag_t     tag;
        bpu_pkg::tag_ctr_t ctr;
    } entry_t;

    logic [TAG_IDX_W-1:0] query_idx;
    bpu_pkg::tag_t        query_tag;
    bpu_pkg::tag_t        query_tag_q;
    entry_t               rd_entry;
    logic [TAG_IDX_W-1:0] upd_idx;
    bpu_pkg::tag_t        upd_tag;
    bpu_pkg::tag_ctr_t    ctr_step;
    logic                 wr_en;
    logic [TAG_IDX_W-1:0] wr_idx;
    entry_t               wr_entry;

    function automatic logic [TAG_IDX_W-1:0] hash_idx(
        input bpu_pkg::pc_t   pc,
        input bpu_pkg::hist_t hist
    );
        logic [HREP*bpu_pkg::HIST_W-1:0] hist_rep;
        hist_rep = {HREP{hist}};
        return pc[TAG_IDX_W+1:2] ^ hist_rep[TAG_IDX_W-1:0];
    endfunction

    // Tag taken from the PC bits just above the index field
    function automatic bpu_pkg::tag_t hash_tag(
        input bpu_pkg::pc_t   pc,
        input bpu_pkg::hist_t hist
    );
        return pc[TAG_IDX_W+2 +: bpu_pkg::TAG_W] ^ hist;
    endfunction

    assign query_idx = hash_idx(query_pc_i, query_hist_i);
    assign query_tag = hash_tag(query_pc_i, query_hist_i);
    assign upd_idx   = hash_idx(upd_pc_i, upd_hist_i);
    assign upd_tag   = hash_tag(upd_pc_i, upd_hist_i);

    // Tag lines up with the entry leaving the RAM
    always_ff @(posedge clk) begin
        query_tag_q <= query_tag;
    end

    assign hit_o = rd_entry.valid && (rd_entry.tag == query_tag_q);
    assign ctr_o = rd_entry.ctr;

    always_comb begin
        if (upd_taken_i) begin
            ctr_step = (upd_ctr_i == '1) ? upd_ctr_i : upd_ctr_i + 1'b1;
        end else begin
            ctr_step = (upd_ctr_i == '0) ? upd_ctr_i : upd_ctr_i - 1'b1;
        end
    end

    always_comb begin
        wr_en          = 1'b0;
        wr_idx         = upd_idx;
        wr_entry.valid = 1'b1;
        wr_entry.tag   = upd_tag;
        wr_entry.ctr   = ctr_step;
        if (clear_i) begin
            wr_en    = 1'b1;
            wr_idx   = clear_idx_i;
            wr_entry = '0;
        end else if (upd_op_i == bpu_pkg::TAG_TRAIN) begin
            wr_en = 1'b1;
        end else if (upd_op_i == bpu_pkg::TAG_ALLOC) begin
            wr_en        = 1'b1;
            wr_entry.ctr = upd_taken_i ? bpu_pkg::TAG_CTR_WEAK_T : bpu_pkg::TAG_CTR_WEAK_NT;
        end
    end

    bpu_bram #(
        .DATA_W($bits(entry_t)),
        .ADDR_W(TAG_IDX_W)
    ) u_table (
        .clk      (clk),
        .rd_addr_i(query_idx),
        .rd_data_o(rd_entry),
        .wr_en_i  (wr_en),
        .wr_addr_i(wr_idx),
        .wr_data_i(wr_entry)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the predictor testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_bpu -Mdir obj_dir -f flist.f

# Result is taken from the log, not from the exit status
./obj_dir/Vtb_bpu | tee "$LOG"

if grep -q "^All checks passed$" "$LOG"; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
